/* logic/chip_ctrl_pkg.sv */
package chip_ctrl_pkg;

  ////////////////////////////////////////////////////
  // Tag frame format
  ////////////////////////////////////////////////////

  localparam int tag_id_width_lp      = 3;
  localparam int tag_num_clients_lp   = 6;
  localparam int tag_payload_width_lp = 8;

  // Start bit, then id msb first, then payload msb first
  localparam int tag_frame_bits_lp    = 1 + tag_id_width_lp + tag_payload_width_lp;
  localparam int tag_count_width_lp   = $clog2(tag_frame_bits_lp);

  localparam int ds_width_lp  = 7;
  localparam int did_width_lp = 7;

  ////////////////////////////////////////////////////
  // Client ids
  ////////////////////////////////////////////////////

  localparam logic [tag_id_width_lp-1:0] tag_id_ds_bp_lp     = 3'd0;
  localparam logic [tag_id_width_lp-1:0] tag_id_ds_io_lp     = 3'd1;
  localparam logic [tag_id_width_lp-1:0] tag_id_ds_router_lp = 3'd2;
  localparam logic [tag_id_width_lp-1:0] tag_id_core_lp      = 3'd3;
  localparam logic [tag_id_width_lp-1:0] tag_id_host_lp      = 3'd4;
  localparam logic [tag_id_width_lp-1:0] tag_id_router_lp    = 3'd5;

  // One payload word, read as a downsampler setting or as a node setting
  typedef union packed
  {
    struct packed
    {
      logic                   reset;
      logic [ds_width_lp-1:0] val;
    } ds;
    struct packed
    {
      logic                    reset;
      logic [did_width_lp-1:0] did;
    } node;
  } tag_payload_u;

endpackage

/* logic/tag_master.sv */
`timescale 1ns/100ps

module tag_master
  (input  logic                                     clk_i
  ,input  logic                                     reset_i
  ,input  logic                                     tag_data_i
  ,input  logic                                     tag_en_i
  ,output logic                                     wr_v_o
  ,output logic [chip_ctrl_pkg::tag_id_width_lp-1:0] wr_id_o
  ,output chip_ctrl_pkg::tag_payload_u              wr_payload_o
  );

  import chip_ctrl_pkg::*;

  logic                          data_li;
  logic                          busy_r;
  logic [tag_count_width_lp-1:0] count_r;
  logic [tag_frame_bits_lp-2:0]  shift_r;
  logic                          wr_v_r;
  logic                          last_bit;

  // Data pin only counts while enabled
  assign data_li = tag_en_i & tag_data_i;

  // Final payload bit is being sampled this cycle
  assign last_bit = busy_r
                    && (count_r == tag_count_width_lp'(tag_frame_bits_lp - 2));

  ////////////////////////////////////////////////////
  // Frame control
  ////////////////////////////////////////////////////

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      busy_r  <= 1'b0;
      count_r <= '0;
      wr_v_r  <= 1'b0;
    end
    else
    begin
      wr_v_r <= last_bit;
      if (!busy_r)
      begin
        // A one while idle is a start bit
        busy_r  <= data_li;
        count_r <= '0;
      end
      else
      begin
        busy_r  <= !last_bit;
        count_r <= count_r + 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////
  // Frame capture
  ////////////////////////////////////////////////////

  always_ff @(posedge clk_i)
  begin
    if (busy_r)
      shift_r <= {shift_r[tag_frame_bits_lp-3:0], data_li};
  end

  assign wr_v_o       = wr_v_r;
  assign wr_id_o      = shift_r[tag_frame_bits_lp-2 -: tag_id_width_lp];
  assign wr_payload_o = shift_r[tag_payload_width_lp-1:0];

  // Frames are at least a start bit plus id and payload long
  wr_single_pulse_a:
    assert property (@(posedge clk_i) disable iff (reset_i)
                     wr_v_o |=> !wr_v_o)
    else $error("tag_master: write pulse held for two cycles");

endmodule

/* logic/tag_client_bank.sv */
`timescale 1ns/100ps

module tag_client_bank
  (input  logic                                     clk_i
  ,input  logic                                     reset_i
  ,input  logic                                     wr_v_i
  ,input  logic [chip_ctrl_pkg::tag_id_width_lp-1:0] wr_id_i
  ,input  chip_ctrl_pkg::tag_payload_u              wr_payload_i
  ,output chip_ctrl_pkg::tag_payload_u              ds_bp_o
  ,output chip_ctrl_pkg::tag_payload_u              ds_io_o
  ,output chip_ctrl_pkg::tag_payload_u              ds_router_o
  ,output chip_ctrl_pkg::tag_payload_u              core_o
  ,output chip_ctrl_pkg::tag_payload_u              host_o
  ,output chip_ctrl_pkg::tag_payload_u              router_o
  );

  import chip_ctrl_pkg::*;

  tag_payload_u [tag_num_clients_lp-1:0] regs_r;

  ////////////////////////////////////////////////////
  // Client registers
  ////////////////////////////////////////////////////

  // Ids past the last client match no register
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      regs_r <= '0;
    end
    else if (wr_v_i)
    begin
      for (int i = 0; i < tag_num_clients_lp; i++)
      begin
        if (wr_id_i == tag_id_width_lp'(i))
          regs_r[i] <= wr_payload_i;
      end
    end
  end

  assign ds_bp_o     = regs_r[tag_id_ds_bp_lp];
  assign ds_io_o     = regs_r[tag_id_ds_io_lp];
  assign ds_router_o = regs_r[tag_id_ds_router_lp];
  assign core_o      = regs_r[tag_id_core_lp];
  assign host_o      = regs_r[tag_id_host_lp];
  assign router_o    = regs_r[tag_id_router_lp];

  // Settings only move on a write from the master
  regs_stable_a:
    assert property (@(posedge clk_i) disable iff (reset_i)
                     !wr_v_i |=> $stable(regs_r))
    else $error("tag_client_bank: client register changed without a write");

endmodule

/* logic/clk_downsampler.sv */
`timescale 1ns/100ps

module clk_downsampler
  (input  logic                        clk_i
  ,input  logic                        reset_i
  ,input  chip_ctrl_pkg::tag_payload_u cfg_i
  ,output logic                        clk_o
  );

  import chip_ctrl_pkg::*;

  logic [ds_width_lp-1:0] count_r;
  logic [ds_width_lp-1:0] val_r;
  logic                   clk_r;
  logic                   hold;
  logic                   toggle;

  assign hold   = reset_i | cfg_i.ds.reset;
  assign toggle = (count_r == val_r);

  ////////////////////////////////////////////////////
  // Divider
  ////////////////////////////////////////////////////

  always_ff @(posedge clk_i)
  begin
    if (hold)
    begin
      count_r <= '0;
      clk_r   <= 1'b0;
      // Pick up the latest divide value so release starts with it
      val_r   <= reset_i ? '0 : cfg_i.ds.val;
    end
    else if (toggle)
    begin
      count_r <= '0;
      clk_r   <= ~clk_r;
      val_r   <= cfg_i.ds.val;
    end
    else
    begin
      count_r <= count_r + 1'b1;
    end
  end

  assign clk_o = clk_r;

  // Endpoint held in reset keeps its clock parked low
  cfg_reset_low_a:
    assert property (@(posedge clk_i) disable iff (reset_i)
                     cfg_i.ds.reset |=> !clk_o)
    else $error("clk_downsampler: clock running while endpoint in reset");

endmodule

/* logic/chip_ctrl.sv */
`timescale 1ns/100ps

module chip_ctrl
  (input  logic                                  clk_i
  ,input  logic                                  reset_i
  ,input  logic                                  tag_data_i
  ,input  logic                                  tag_en_i
  ,input  logic [1:0]                            sel_i
  ,output logic                                  clk_o
  ,output logic                                  core_reset_o
  ,output logic                                  host_reset_o
  ,output logic                                  router_reset_o
  ,output logic [chip_ctrl_pkg::did_width_lp-1:0] core_did_o
  ,output logic [chip_ctrl_pkg::did_width_lp-1:0] host_did_o
  ,output logic [chip_ctrl_pkg::did_width_lp-1:0] router_did_o
  );

  import chip_ctrl_pkg::*;

  ////////////////////////////////////////////////////
  // Tag master and client bank
  ////////////////////////////////////////////////////

  logic                       wr_v_lo;
  logic [tag_id_width_lp-1:0] wr_id_lo;
  tag_payload_u               wr_payload_lo;

  tag_payload_u ds_bp_lo;
  tag_payload_u ds_io_lo;
  tag_payload_u ds_router_lo;
  tag_payload_u core_lo;
  tag_payload_u host_lo;
  tag_payload_u router_lo;

  tag_master master
    (.clk_i       ( clk_i )
    ,.reset_i     ( reset_i )
    ,.tag_data_i  ( tag_data_i )
    ,.tag_en_i    ( tag_en_i )
    ,.wr_v_o      ( wr_v_lo )
    ,.wr_id_o     ( wr_id_lo )
    ,.wr_payload_o( wr_payload_lo )
    );

  tag_client_bank bank
    (.clk_i       ( clk_i )
    ,.reset_i     ( reset_i )
    ,.wr_v_i      ( wr_v_lo )
    ,.wr_id_i     ( wr_id_lo )
    ,.wr_payload_i( wr_payload_lo )
    ,.ds_bp_o     ( ds_bp_lo )
    ,.ds_io_o     ( ds_io_lo )
    ,.ds_router_o ( ds_router_lo )
    ,.core_o      ( core_lo )
    ,.host_o      ( host_lo )
    ,.router_o    ( router_lo )
    );

  // Node settings go straight to the pins
  assign core_reset_o   = core_lo.node.reset;
  assign core_did_o     = core_lo.node.did;
  assign host_reset_o   = host_lo.node.reset;
  assign host_did_o     = host_lo.node.did;
  assign router_reset_o = router_lo.node.reset;
  assign router_did_o   = router_lo.node.did;

  ////////////////////////////////////////////////////
  // Endpoint clocks
  ////////////////////////////////////////////////////

  logic bp_clk_lo;
  logic io_master_clk_lo;
  logic router_clk_lo;

  clk_downsampler ds_bp
    (.clk_i  ( clk_i )
    ,.reset_i( reset_i )
    ,.cfg_i  ( ds_bp_lo )
    ,.clk_o  ( bp_clk_lo )
    );

  clk_downsampler ds_io
    (.clk_i  ( clk_i )
    ,.reset_i( reset_i )
    ,.cfg_i  ( ds_io_lo )
    ,.clk_o  ( io_master_clk_lo )
    );

  clk_downsampler ds_router
    (.clk_i  ( clk_i )
    ,.reset_i( reset_i )
    ,.cfg_i  ( ds_router_lo )
    ,.clk_o  ( router_clk_lo )
    );

  // Last leg of the clock out select is tied off
  always_comb
  begin
    case (sel_i)
      2'd0:    clk_o = router_clk_lo;
      2'd1:    clk_o = io_master_clk_lo;
      2'd2:    clk_o = bp_clk_lo;
      default: clk_o = 1'b0;
    endcase
  end

endmodule

/* verif/chip_ctrl_tb.sv */
`timescale 1ns/100ps

module chip_ctrl_tb;

  import chip_ctrl_pkg::*;

  logic                    clk_i;
  logic                    reset_i;
  logic                    tag_data_i;
  logic                    tag_en_i;
  logic [1:0]              sel_i;
  logic                    clk_o;
  logic                    core_reset_o;
  logic                    host_reset_o;
  logic                    router_reset_o;
  logic [did_width_lp-1:0] core_did_o;
  logic [did_width_lp-1:0] host_did_o;
  logic [did_width_lp-1:0] router_did_o;

  // Expected payload word per client id
  logic [tag_payload_width_lp-1:0] model_r [tag_num_clients_lp];

  int unsigned err_count;
  int unsigned timeout_count;

  // Run lengths of clk_o sampled mid-cycle
  logic        clk_last = 1'b0;
  logic        toggled  = 1'b0;
  int unsigned run_len  = 0;
  int unsigned last_run = 0;
  logic        period_check_en;
  int unsigned exp_run;
  logic        ep_hold;

  chip_ctrl chip_ctrl_i
    (.clk_i         ( clk_i )
    ,.reset_i       ( reset_i )
    ,.tag_data_i    ( tag_data_i )
    ,.tag_en_i      ( tag_en_i )
    ,.sel_i         ( sel_i )
    ,.clk_o         ( clk_o )
    ,.core_reset_o  ( core_reset_o )
    ,.host_reset_o  ( host_reset_o )
    ,.router_reset_o( router_reset_o )
    ,.core_did_o    ( core_did_o )
    ,.host_did_o    ( host_did_o )
    ,.router_did_o  ( router_did_o )
    );

  initial
  begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  always @(negedge clk_i)
  begin
    if (clk_o != clk_last)
    begin
      toggled  <= 1'b1;
      last_run <= run_len;
      run_len  <= 1;
    end
    else
    begin
      toggled <= 1'b0;
      run_len <= run_len + 1;
    end
    clk_last <= clk_o;
  end

  // Selected endpoint is parked low by its reset bit, or the output is tied off
  always_comb
  begin
    case (sel_i)
      2'd0:    ep_hold = model_r[tag_id_ds_router_lp][7];
      2'd1:    ep_hold = model_r[tag_id_ds_io_lp][7];
      2'd2:    ep_hold = model_r[tag_id_ds_bp_lp][7];
      default: ep_hold = 1'b1;
    endcase
  end

  function automatic void report_mismatch(string name, int unsigned exp, int unsigned act);
    $display("FAILED at %0t: %s expected %0h actual %0h", $time, name, exp, act);
    err_count++;
  endfunction

  function automatic logic [tag_id_width_lp-1:0] ds_id_for_sel(logic [1:0] sel);
    case (sel)
      2'd0:    return tag_id_ds_router_lp;
      2'd1:    return tag_id_ds_io_lp;
      default: return tag_id_ds_bp_lp;
    endcase
  endfunction

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////

  core_reset_a: assert property (@(posedge clk_i) disable iff (reset_i)
                                 core_reset_o == model_r[tag_id_core_lp][7])
    else report_mismatch("core_reset_o", 32'($sampled(model_r[tag_id_core_lp][7])),
                         32'($sampled(core_reset_o)));

  core_did_a: assert property (@(posedge clk_i) disable iff (reset_i)
                               core_did_o == model_r[tag_id_core_lp][6:0])
    else report_mismatch("core_did_o", 32'($sampled(model_r[tag_id_core_lp][6:0])),
                         32'($sampled(core_did_o)));

  host_reset_a: assert property (@(posedge clk_i) disable iff (reset_i)
                                 host_reset_o == model_r[tag_id_host_lp][7])
    else report_mismatch("host_reset_o", 32'($sampled(model_r[tag_id_host_lp][7])),
                         32'($sampled(host_reset_o)));

  host_did_a: assert property (@(posedge clk_i) disable iff (reset_i)
                               host_did_o == model_r[tag_id_host_lp][6:0])
    else report_mismatch("host_did_o", 32'($sampled(model_r[tag_id_host_lp][6:0])),
                         32'($sampled(host_did_o)));

  router_reset_a: assert property (@(posedge clk_i) disable iff (reset_i)
                                   router_reset_o == model_r[tag_id_router_lp][7])
    else report_mismatch("router_reset_o", 32'($sampled(model_r[tag_id_router_lp][7])),
                         32'($sampled(router_reset_o)));

  router_did_a: assert property (@(posedge clk_i) disable iff (reset_i)
                                 router_did_o == model_r[tag_id_router_lp][6:0])
    else report_mismatch("router_did_o", 32'($sampled(model_r[tag_id_router_lp][6:0])),
                         32'($sampled(router_did_o)));

  clk_period_a: assert property (@(posedge clk_i) disable iff (reset_i)
                                 (period_check_en && toggled) |-> (last_run == exp_run))
    else report_mismatch("clk_o run length", $sampled(exp_run), $sampled(last_run));

  // Downsampler reacts one cycle after its reset bit lands
  clk_held_a: assert property (@(posedge clk_i) disable iff (reset_i)
                               (ep_hold && $past(ep_hold)) |-> !clk_o)
    else report_mismatch("clk_o held", 0, 32'($sampled(clk_o)));

  clk_tied_off_a: assert property (@(posedge clk_i) disable iff (reset_i)
                                   (sel_i == 2'd3) |-> !clk_o)
    else report_mismatch("clk_o tied off", 0, 32'($sampled(clk_o)));

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  // Between frames the pin is either disabled with junk on it or sends zeros
  task automatic drive_idle(input int unsigned cycles);
    repeat (cycles)
    begin
      @(posedge clk_i);
      if ($urandom_range(1, 0) == 0)
      begin
        tag_en_i   <= 1'b0;
        tag_data_i <= 1'($urandom_range(1, 0));
      end
      else
      begin
        tag_en_i   <= 1'b1;
        tag_data_i <= 1'b0;
      end
    end
  endtask

  task automatic drive_noise(input int unsigned cycles);
    repeat (cycles)
    begin
      @(posedge clk_i);
      tag_en_i   <= 1'b0;
      tag_data_i <= 1'($urandom_range(1, 0));
    end
  endtask

  task automatic send_frame(input logic [tag_id_width_lp-1:0] id,
                            input logic [tag_payload_width_lp-1:0] payload);
    logic [tag_frame_bits_lp-1:0] frame;
    frame = {1'b1, id, payload};
    for (int i = tag_frame_bits_lp - 1; i >= 0; i--)
    begin
      @(posedge clk_i);
      tag_en_i   <= 1'b1;
      tag_data_i <= frame[i];
    end
    // Last bit is sampled here and the client register loads one edge later
    drive_idle(1);
    @(posedge clk_i);
    if (id < tag_id_width_lp'(tag_num_clients_lp))
      model_r[id] <= payload;
  endtask

  task automatic set_select(input logic [1:0] sel);
    @(posedge clk_i);
    sel_i           <= sel;
    period_check_en <= 1'b0;
  endtask

  task automatic wait_for_toggles(input int unsigned count);
    int unsigned seen;
    int unsigned cycles;
    seen   = 0;
    cycles = 0;
    while (seen < count && cycles < 64)
    begin
      @(posedge clk_i);
      cycles++;
      if (toggled)
        seen++;
    end
    if (seen < count)
    begin
      $display("Timeout at %0t: clk_o stopped toggling on select %0d", $time, sel_i);
      timeout_count++;
    end
  endtask

  // Skip the runs that straddle the last change, then keep checking
  task automatic check_period(input int unsigned d, input int unsigned cycles);
    exp_run <= d + 1;
    wait_for_toggles(3);
    period_check_en <= 1'b1;
    drive_idle(cycles);
  endtask

  initial
  begin
    int unsigned d;
    logic [1:0]  sel;
    void'($urandom(32'h2731));
    reset_i         = 1'b1;
    tag_data_i      = 1'b0;
    tag_en_i        = 1'b0;
    sel_i           = 2'd0;
    period_check_en = 1'b0;
    exp_run         = 1;
    err_count       = 0;
    timeout_count   = 0;
    for (int i = 0; i < tag_num_clients_lp; i++)
      model_r[i] = '0;

    repeat (4) @(posedge clk_i);
    reset_i <= 1'b0;

    // Router clock toggles every cycle out of reset
    drive_idle(4);
    check_period(0, 12);

    // Node clients
    for (int k = 0; k < 9; k++)
    begin
      send_frame(tag_id_width_lp'(3 + k % 3), 8'($urandom));
      drive_idle($urandom_range(3, 0));
    end

    // Divide values on random endpoints
    for (int k = 0; k < 8; k++)
    begin
      sel = 2'($urandom_range(2, 0));
      d   = $urandom_range(5, 0);
      set_select(sel);
      send_frame(ds_id_for_sel(sel), {1'b0, 7'(d)});
      check_period(d, 4 * (d + 1) + 4);
    end

    // Endpoint reset and tied-off output
    set_select(2'd1);
    send_frame(tag_id_ds_io_lp, 8'h82);
    drive_idle(12);
    set_select(2'd3);
    for (int k = 0; k < 4; k++)
    begin
      send_frame(tag_id_width_lp'($urandom_range(5, 3)), 8'($urandom));
      drive_idle(2);
    end
    send_frame(tag_id_ds_io_lp, 8'h03);
    set_select(2'd1);
    check_period(3, 20);

    // Unused ids and a disabled pin leave everything alone
    set_select(2'd0);
    send_frame(tag_id_ds_router_lp, 8'h02);
    check_period(2, 12);
    send_frame(3'd6, 8'($urandom));
    send_frame(3'd7, 8'($urandom));
    drive_noise(30);
    drive_idle(12);

    $display("Checks done: %0d value errors, %0d timeouts", err_count, timeout_count);
    if (err_count == 0 && timeout_count == 0)
      $display("RESULT: PASS");
    else
      $display("RESULT: FAIL");
    $finish;
  end

endmodule

/* chip_ctrl.f */
logic/chip_ctrl_pkg.sv
logic/tag_master.sv
logic/tag_client_bank.sv
logic/clk_downsampler.sv
logic/chip_ctrl.sv
verif/chip_ctrl_tb.sv

/* run.sh */
#!/bin/bash
# Build and run the chip_ctrl testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --assert -Wno-fatal --top-module chip_ctrl_tb \
  -f chip_ctrl.f -o chip_ctrl_sim \
  && ./obj_dir/chip_ctrl_sim > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "Simulation did not build or run to the end"; exit 1; }

cat sim.log
grep -q "^RESULT: PASS$" sim.log \
  && { echo "Simulation passed"; exit 0; } \
  || { echo "Simulation failed"; exit 1; }
